// ==== rtl/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  mem_size_t; // bit 2 of the load/store funct3 set means zero extend

  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10; // lui

  typedef logic [1:0] opa_sel_t;
  localparam opa_sel_t OPA_RS1  = 2'd0;
  localparam opa_sel_t OPA_PC   = 2'd1;
  localparam opa_sel_t OPA_ZERO = 2'd2;

  typedef logic opb_sel_t;
  localparam opb_sel_t OPB_RS2 = 1'b0;
  localparam opb_sel_t OPB_IMM = 1'b1;

  typedef logic [1:0] wb_sel_t;
  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_LOAD = 2'd1;
  localparam wb_sel_t WB_PC4  = 2'd2;

  typedef logic [1:0] pc_sel_t;
  localparam pc_sel_t PC_SEQ    = 2'd0;
  localparam pc_sel_t PC_BRANCH = 2'd1;
  localparam pc_sel_t PC_JAL    = 2'd2;
  localparam pc_sel_t PC_JALR   = 2'd3;

  // branch funct3 encodings
  typedef logic [2:0] br_cond_t;
  localparam br_cond_t BR_EQ  = 3'b000;
  localparam br_cond_t BR_NE  = 3'b001;
  localparam br_cond_t BR_LT  = 3'b100;
  localparam br_cond_t BR_GE  = 3'b101;
  localparam br_cond_t BR_LTU = 3'b110;
  localparam br_cond_t BR_GEU = 3'b111;

  typedef struct packed {
    alu_op_t   alu_op;
    opa_sel_t  opa_sel;
    opb_sel_t  opb_sel;
    wb_sel_t   wb_sel;
    pc_sel_t   pc_sel;
    br_cond_t  br_cond;
    logic      reg_wen;
    logic      mem_wen;
    logic      mem_ren;
    mem_size_t mem_size;
    logic      ebreak;
  } ctrl_t;

  // one register write per retired instruction
  typedef struct packed {
    logic      wen;
    reg_addr_t rd;
    xlen_t     wdata;
  } commit_t;

endpackage

`default_nettype wire

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_core_pkg::*; (
  input  wire inst_t inst_i,
  output ctrl_t      ctrl_o,
  output reg_addr_t  rs1_o,
  output reg_addr_t  rs2_o,
  output reg_addr_t  rd_o,
  output xlen_t      imm_o
);

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam inst_t EBREAK_WORD = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  xlen_t      imm_i_fmt;
  xlen_t      imm_s_fmt;
  xlen_t      imm_b_fmt;
  xlen_t      imm_u_fmt;
  xlen_t      imm_j_fmt;

  // sub only exists in the register form
  function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic f7_b5,
                                              input logic is_reg);
    alu_op_t op;
    case (f3)
      3'b000:  op = (is_reg && f7_b5) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = f7_b5 ? ALU_SRA : ALU_SRL; // bit 30 marks sra/srai in both forms
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode    = inst_i[6:0];
  assign funct3    = inst_i[14:12];
  assign funct7_b5 = inst_i[30];

  assign rs1_o = inst_i[19:15];
  assign rs2_o = inst_i[24:20];
  assign rd_o  = inst_i[11:7];

  assign imm_i_fmt = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_fmt = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b_fmt = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u_fmt = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j_fmt = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    // anything not matched below falls through as a no-op
    ctrl_o          = '0;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.opa_sel  = OPA_RS1;
    ctrl_o.opb_sel  = OPB_IMM;
    ctrl_o.wb_sel   = WB_ALU;
    ctrl_o.pc_sel   = PC_SEQ;
    ctrl_o.br_cond  = funct3;
    ctrl_o.mem_size = funct3;
    imm_o           = imm_i_fmt;

    case (opcode)
      OP_LUI: begin
        ctrl_o.opa_sel = OPA_ZERO;
        ctrl_o.alu_op  = ALU_PASS_B;
        ctrl_o.reg_wen = 1'b1;
        imm_o          = imm_u_fmt;
      end
      OP_AUIPC: begin
        ctrl_o.opa_sel = OPA_PC;
        ctrl_o.reg_wen = 1'b1;
        imm_o          = imm_u_fmt;
      end
      OP_JAL: begin
        ctrl_o.opa_sel = OPA_PC;
        ctrl_o.wb_sel  = WB_PC4;
        ctrl_o.pc_sel  = PC_JAL;
        ctrl_o.reg_wen = 1'b1;
        imm_o          = imm_j_fmt;
      end
      OP_JALR: begin
        ctrl_o.wb_sel  = WB_PC4; // target comes from the ALU adder
        ctrl_o.pc_sel  = PC_JALR;
        ctrl_o.reg_wen = 1'b1;
      end
      OP_BRANCH: begin
        ctrl_o.pc_sel = PC_BRANCH;
        imm_o         = imm_b_fmt;
      end
      OP_LOAD: begin
        ctrl_o.wb_sel  = WB_LOAD;
        ctrl_o.reg_wen = 1'b1;
        ctrl_o.mem_ren = 1'b1;
      end
      OP_STORE: begin
        ctrl_o.mem_wen = 1'b1;
        imm_o          = imm_s_fmt;
      end
      OP_IMM: begin
        ctrl_o.alu_op  = alu_from_funct3(funct3, funct7_b5, 1'b0);
        ctrl_o.reg_wen = 1'b1;
      end
      OP_REG: begin
        ctrl_o.alu_op  = alu_from_funct3(funct3, funct7_b5, 1'b1);
        ctrl_o.opb_sel = OPB_RS2;
        ctrl_o.reg_wen = 1'b1;
      end
      OP_SYSTEM: begin
        ctrl_o.ebreak = (inst_i == EBREAK_WORD); // ecall and friends stay no-ops
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
  input  wire            clk,
  input  wire            rst_i,
  input  wire commit_t   wr_i,
  input  wire reg_addr_t rs1_i,
  input  wire reg_addr_t rs2_i,
  output xlen_t          rs1_data_o,
  output xlen_t          rs2_data_o
);

  xlen_t regs [32];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_i.wen && (wr_i.rd != '0)) begin
      regs[wr_i.rd] <= wr_i.wdata; // x0 never gets written
    end
  end

  // reads return the value from before this cycle's write
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== rtl/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_core_pkg::*; (
  input  wire ctrl_t ctrl_i,
  input  wire xlen_t pc_i,
  input  wire xlen_t rs1_data_i,
  input  wire xlen_t rs2_data_i,
  input  wire xlen_t imm_i,
  output xlen_t      result_o
);

  xlen_t      op_a;
  xlen_t      op_b;
  logic [5:0] shamt;

  always_comb begin
    case (ctrl_i.opa_sel)
      OPA_PC:   op_a = pc_i;
      OPA_ZERO: op_a = '0;
      default:  op_a = rs1_data_i;
    endcase
    op_b = (ctrl_i.opb_sel == OPB_IMM) ? imm_i : rs2_data_i;
  end

  assign shamt = op_b[5:0]; // RV64 shifts take six bits

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_SUB:    result_o = op_a - op_b;
      ALU_SLL:    result_o = op_a << shamt;
      ALU_SLT:    result_o = {63'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result_o = {63'b0, op_a < op_b};
      ALU_XOR:    result_o = op_a ^ op_b;
      ALU_SRL:    result_o = op_a >> shamt;
      ALU_SRA:    result_o = $signed(op_a) >>> shamt;
      ALU_OR:     result_o = op_a | op_b;
      ALU_AND:    result_o = op_a & op_b;
      ALU_PASS_B: result_o = op_b;
      default:    result_o = op_a + op_b; // also the load/store address and jalr target
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit import rv_core_pkg::*; #(
  parameter xlen_t RESET_PC = 64'h8000_0000
) (
  input  wire        clk,
  input  wire        rst_i,
  input  wire ctrl_t ctrl_i,
  input  wire xlen_t rs1_data_i,
  input  wire xlen_t rs2_data_i,
  input  wire xlen_t imm_i,
  input  wire xlen_t alu_result_i,
  output xlen_t      pc_o,
  output xlen_t      pc_plus4_o,
  output logic       halted_o
);

  xlen_t pc_next;
  logic  is_eq;
  logic  is_lt;
  logic  is_ltu;
  logic  taken;

  assign is_eq  = (rs1_data_i == rs2_data_i);
  assign is_lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign is_ltu = (rs1_data_i < rs2_data_i);

  always_comb begin
    case (ctrl_i.br_cond)
      BR_EQ:   taken = is_eq;
      BR_NE:   taken = !is_eq;
      BR_LT:   taken = is_lt;
      BR_GE:   taken = !is_lt;
      BR_LTU:  taken = is_ltu;
      BR_GEU:  taken = !is_ltu;
      default: taken = 1'b0; // reserved encodings fall through
    endcase
  end

  assign pc_plus4_o = pc_o + 64'd4;

  always_comb begin
    case (ctrl_i.pc_sel)
      PC_BRANCH: pc_next = taken ? (pc_o + imm_i) : pc_plus4_o;
      PC_JAL:    pc_next = pc_o + imm_i;
      PC_JALR:   pc_next = {alu_result_i[63:1], 1'b0};
      default:   pc_next = pc_plus4_o;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_o     <= RESET_PC;
      halted_o <= 1'b0;
    end else if (!halted_o) begin
      if (ctrl_i.ebreak) begin
        halted_o <= 1'b1; // pc stays on the ebreak
      end else begin
        pc_o <= pc_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rv_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_data_ram import rv_core_pkg::*; #(
  parameter int DATA_WORDS = 512
) (
  input  wire        clk,
  input  wire ctrl_t ctrl_i,
  input  wire xlen_t addr_i,
  input  wire xlen_t wdata_i,
  output xlen_t      rdata_o
);

  localparam int IDX_W = $clog2(DATA_WORDS);

  xlen_t            mem [DATA_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic [2:0]       byte_off;
  logic [5:0]       bit_off;
  xlen_t            word_rd;
  xlen_t            rd_shifted;
  logic             sext;
  logic [7:0]       size_mask;
  logic [7:0]       wstrb;
  xlen_t            wdata_lane;

  // the word index takes the low address bits and ignores the window base
  assign byte_off = addr_i[2:0];
  assign word_idx = addr_i[IDX_W+2:3];
  assign bit_off  = {byte_off, 3'b000};

  assign word_rd    = mem[word_idx];
  assign rd_shifted = word_rd >> bit_off;
  assign sext       = !ctrl_i.mem_size[2];

  always_comb begin
    rdata_o = '0;
    if (ctrl_i.mem_ren) begin
      case (ctrl_i.mem_size[1:0])
        2'b00:   rdata_o = {{56{sext & rd_shifted[7]}}, rd_shifted[7:0]};
        2'b01:   rdata_o = {{48{sext & rd_shifted[15]}}, rd_shifted[15:0]};
        2'b10:   rdata_o = {{32{sext & rd_shifted[31]}}, rd_shifted[31:0]};
        default: rdata_o = rd_shifted;
      endcase
    end
  end

  always_comb begin
    case (ctrl_i.mem_size[1:0])
      2'b00:   size_mask = 8'h01;
      2'b01:   size_mask = 8'h03;
      2'b10:   size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  assign wstrb      = size_mask << byte_off;
  assign wdata_lane = wdata_i << bit_off;

  // byte lanes outside the store size keep their old content
  always_ff @(posedge clk) begin
    if (ctrl_i.mem_wen) begin
      for (int b = 0; b < 8; b++) begin
        if (wstrb[b]) begin
          mem[word_idx][b*8 +: 8] <= wdata_lane[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_core_pkg::*; #(
  parameter xlen_t RESET_PC   = 64'h8000_0000,
  parameter int    DATA_WORDS = 512
) (
  input  wire        clk,
  input  wire        rst_i,
  output xlen_t      pc_o,
  input  wire inst_t inst_i,
  output commit_t    commit_o,
  output logic       halted_o
);

  ctrl_t     ctrl;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  xlen_t     imm;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     alu_result;
  xlen_t     load_data;
  xlen_t     pc_plus4;
  xlen_t     wb_data;

  rv_decoder u_decoder (
    .inst_i (inst_i),
    .ctrl_o (ctrl),
    .rs1_o  (rs1),
    .rs2_o  (rs2),
    .rd_o   (rd),
    .imm_o  (imm)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst_i      (rst_i),
    .wr_i       (commit_o),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_alu u_alu (
    .ctrl_i     (ctrl),
    .pc_i       (pc_o),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .imm_i      (imm),
    .result_o   (alu_result)
  );

  rv_pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc_unit (
    .clk          (clk),
    .rst_i        (rst_i),
    .ctrl_i       (ctrl),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .imm_i        (imm),
    .alu_result_i (alu_result),
    .pc_o         (pc_o),
    .pc_plus4_o   (pc_plus4),
    .halted_o     (halted_o)
  );

  rv_data_ram #(
    .DATA_WORDS (DATA_WORDS)
  ) u_data_ram (
    .clk     (clk),
    .ctrl_i  (ctrl),
    .addr_i  (alu_result),
    .wdata_i (rs2_data),
    .rdata_o (load_data)
  );

  always_comb begin
    case (ctrl.wb_sel)
      WB_LOAD: wb_data = load_data;
      WB_PC4:  wb_data = pc_plus4; // link address of jal and jalr
      default: wb_data = alu_result;
    endcase
    commit_o = '{wen: ctrl.reg_wen & ~halted_o, rd: rd, wdata: wb_data};
  end

endmodule

`default_nettype wire

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_core_pkg::*; ();

  localparam xlen_t      BASE     = 64'h8000_0000;
  localparam inst_t      NOP      = 32'h0000_0013; // addi x0, x0, 0
  localparam logic [6:0] OPC_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_JALR = 7'b1100111;

  typedef struct packed {
    inst_t   inst;
    xlen_t   pc;
    commit_t commit;
    logic    halted;
  } row_t;

  logic    clk = 1'b0;
  logic    rst_i;
  inst_t   inst_i;
  xlen_t   pc_o;
  commit_t commit_o;
  logic    halted_o;
  row_t    rows [$];
  string   names [$];
  xlen_t   tbl_pc;
  logic    tbl_halted;

  rv_core #(.RESET_PC(BASE), .DATA_WORDS(512)) dut (
    .clk      (clk),
    .rst_i    (rst_i),
    .pc_o     (pc_o),
    .inst_i   (inst_i),
    .commit_o (commit_o),
    .halted_o (halted_o)
  );

  always #50 clk = ~clk;

  function automatic inst_t r_type(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
                                   input reg_addr_t rs1, input reg_addr_t rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic inst_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                   input reg_addr_t rd, input reg_addr_t rs1,
                                   input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t s_type(input logic [2:0] f3, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic inst_t b_type(input logic [2:0] f3, input reg_addr_t rs1,
                                   input reg_addr_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic stop_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_commit(input string name, input commit_t exp, input commit_t act);
    logic bad;
    bad = (act.wen !== exp.wen);
    if (exp.wen) begin
      bad = bad || (act.rd !== exp.rd) || (act.wdata !== exp.wdata); // only a real write has data
    end
    if (bad) begin
      $display("mismatch %s: expected wen %b rd %0d wdata %h, actual wen %b rd %0d wdata %h",
               name, exp.wen, exp.rd, exp.wdata, act.wen, act.rd, act.wdata);
      stop_run();
    end
  endtask

  // each row sits at the current pc and sequential flow moves on by 4
  task automatic add_row(input string name, input inst_t inst, input logic wen,
                         input reg_addr_t rd, input xlen_t wdata);
    names.push_back(name);
    rows.push_back({inst, tbl_pc, wen, rd, wdata, tbl_halted});
    if (!tbl_halted) begin
      tbl_pc = tbl_pc + 64'd4;
    end
  endtask

  task automatic move_pc(input xlen_t target);
    tbl_pc = target;
  endtask

  task automatic freeze_pc();
    tbl_pc     = tbl_pc - 64'd4; // the core stays on the ebreak
    tbl_halted = 1'b1;
  endtask

  task automatic build_table();
    tbl_pc     = BASE;
    tbl_halted = 1'b0;
    add_row("addi x1", i_type(OPC_IMM, 3'd0, 5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 64'd5);
    add_row("addi x2", i_type(OPC_IMM, 3'd0, 5'd2, 5'd0, 12'hffd), 1'b1, 5'd2, -64'sd3);
    add_row("lui x3", 32'h1234_51b7, 1'b1, 5'd3, 64'h0000_0000_1234_5000);
    add_row("lui x4", 32'h8000_0237, 1'b1, 5'd4, 64'hffff_ffff_8000_0000);
    add_row("auipc x5", 32'h0000_1297, 1'b1, 5'd5, BASE + 64'h10 + 64'h1000);
    add_row("add", r_type(3'd0, 1'b0, 5'd6, 5'd1, 5'd2), 1'b1, 5'd6, 64'd2);
    add_row("sub", r_type(3'd0, 1'b1, 5'd7, 5'd1, 5'd2), 1'b1, 5'd7, 64'd8);
    add_row("and", r_type(3'd7, 1'b0, 5'd8, 5'd6, 5'd2), 1'b1, 5'd8, 64'd0);
    add_row("or", r_type(3'd6, 1'b0, 5'd9, 5'd1, 5'd3), 1'b1, 5'd9, 64'h1234_5005);
    add_row("xor", r_type(3'd4, 1'b0, 5'd11, 5'd2, 5'd1), 1'b1, 5'd11, -64'sd8);
    add_row("sll", r_type(3'd1, 1'b0, 5'd12, 5'd1, 5'd1), 1'b1, 5'd12, 64'ha0);
    add_row("srl", r_type(3'd5, 1'b0, 5'd13, 5'd4, 5'd1), 1'b1, 5'd13, 64'h07ff_ffff_fc00_0000);
    add_row("sra", r_type(3'd5, 1'b1, 5'd14, 5'd4, 5'd1), 1'b1, 5'd14, 64'hffff_ffff_fc00_0000);
    add_row("slt", r_type(3'd2, 1'b0, 5'd15, 5'd2, 5'd1), 1'b1, 5'd15, 64'd1);
    add_row("sltu", r_type(3'd3, 1'b0, 5'd16, 5'd2, 5'd1), 1'b1, 5'd16, 64'd0);
    add_row("slli", i_type(OPC_IMM, 3'd1, 5'd17, 5'd1, 12'd40), 1'b1, 5'd17, 64'h0500_0000_0000);
    add_row("addi x0", i_type(OPC_IMM, 3'd0, 5'd0, 5'd0, 12'd5), 1'b1, 5'd0, 64'd5);
    add_row("read x0", r_type(3'd0, 1'b0, 5'd20, 5'd0, 5'd0), 1'b1, 5'd20, 64'd0);
    // x1 = 5 and x2 = -3 from here on
    add_row("beq taken", b_type(3'd0, 5'd1, 5'd1, 13'd8), 1'b0, 5'd0, 64'd0);
    move_pc(BASE + 64'h48 + 64'd8);
    add_row("beq not taken", b_type(3'd0, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0);
    add_row("bne taken", b_type(3'd1, 5'd1, 5'd2, 13'd12), 1'b0, 5'd0, 64'd0);
    move_pc(BASE + 64'h54 + 64'd12);
    add_row("bne not taken", b_type(3'd1, 5'd1, 5'd1, 13'd8), 1'b0, 5'd0, 64'd0);
    add_row("blt taken", b_type(3'd4, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 64'd0);
    move_pc(BASE + 64'h64 + 64'd8);
    add_row("blt not taken", b_type(3'd4, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0);
    add_row("bge taken back", b_type(3'd5, 5'd1, 5'd2, 13'h1ff8), 1'b0, 5'd0, 64'd0);
    move_pc(BASE + 64'h70 - 64'd8);
    add_row("bge not taken", b_type(3'd5, 5'd2, 5'd1, 13'd16), 1'b0, 5'd0, 64'd0);
    add_row("bltu taken", b_type(3'd6, 5'd1, 5'd2, 13'd16), 1'b0, 5'd0, 64'd0);
    move_pc(BASE + 64'h6c + 64'd16);
    add_row("bltu not taken", b_type(3'd6, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 64'd0);
    add_row("bgeu taken", b_type(3'd7, 5'd2, 5'd1, 13'd8), 1'b0, 5'd0, 64'd0);
    move_pc(BASE + 64'h80 + 64'd8);
    add_row("bgeu not taken", b_type(3'd7, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 64'd0);
    add_row("jal x21", 32'h00c0_0aef, 1'b1, 5'd21, BASE + 64'h90);
    move_pc(BASE + 64'h8c + 64'd12);
    add_row("auipc x10", 32'h0000_0517, 1'b1, 5'd10, BASE + 64'h98);
    add_row("jalr x22", i_type(OPC_JALR, 3'd0, 5'd22, 5'd10, 12'h021), 1'b1, 5'd22, BASE + 64'ha0);
    move_pc((BASE + 64'h98 + 64'h21) & ~64'h1);
    // data sits at x10 and the narrower stores fill the word after it
    add_row("sd", s_type(3'd3, 5'd3, 5'd10, 12'd0), 1'b0, 5'd0, 64'd0);
    add_row("sw", s_type(3'd2, 5'd4, 5'd10, 12'd8), 1'b0, 5'd0, 64'd0);
    add_row("sh", s_type(3'd1, 5'd2, 5'd10, 12'd12), 1'b0, 5'd0, 64'd0);
    add_row("sb", s_type(3'd0, 5'd11, 5'd10, 12'd14), 1'b0, 5'd0, 64'd0);
    add_row("ld", i_type(OPC_LOAD, 3'd3, 5'd23, 5'd10, 12'd0), 1'b1, 5'd23, 64'h1234_5000);
    add_row("lb", i_type(OPC_LOAD, 3'd0, 5'd24, 5'd10, 12'd14), 1'b1, 5'd24, -64'sd8);
    add_row("lbu", i_type(OPC_LOAD, 3'd4, 5'd25, 5'd10, 12'd14), 1'b1, 5'd25, 64'hf8);
    add_row("lh", i_type(OPC_LOAD, 3'd1, 5'd26, 5'd10, 12'd12), 1'b1, 5'd26, -64'sd3);
    add_row("lhu", i_type(OPC_LOAD, 3'd5, 5'd27, 5'd10, 12'd10), 1'b1, 5'd27, 64'h8000);
    add_row("lw", i_type(OPC_LOAD, 3'd2, 5'd28, 5'd10, 12'd8), 1'b1, 5'd28, 64'hffff_ffff_8000_0000);
    add_row("lwu", i_type(OPC_LOAD, 3'd6, 5'd29, 5'd10, 12'd8), 1'b1, 5'd29, 64'h8000_0000);
    add_row("ebreak", 32'h0010_0073, 1'b0, 5'd0, 64'd0);
    freeze_pc();
    add_row("halted addi", i_type(OPC_IMM, 3'd0, 5'd1, 5'd0, 12'd1), 1'b0, 5'd0, 64'd0);
    add_row("halted jal", 32'h00c0_0aef, 1'b0, 5'd0, 64'd0);
  endtask

  initial begin
    rst_i  = 1'b1;
    inst_i = NOP;
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      check_xlen({names[i], " pc"}, rows[i].pc, pc_o);
      check_bit({names[i], " halted"}, rows[i].halted, halted_o);
      inst_i = rows[i].inst;
      #1;
      check_commit(names[i], rows[i].commit, commit_o); // settled combinational result
      @(negedge clk);
    end
    $display("Everything OK");
    $finish;
  end

  initial begin
    #1;
    #((rows.size() + 10) * 100);
    $display("timeout: the core did not get through all table rows in time");
    stop_run();
  end

endmodule

`default_nettype wire

// ==== rv_core.f ====
rtl/rv_core_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_pc_unit.sv
rtl/rv_data_ram.sv
rtl/rv_core.sv
test/rv_core_tb.sv
